// File: hw/px_cycle_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// P-X cycle control, top level
// State register, group decode, strobe generators and merge
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module px_cycle_ctrl #(
	// Group 1 in the low nibble, widths 5 6 5 5 5
	parameter logic [px_pkg::N_GROUPS-1:0][3:0] STROB1_WIDTHS =
		{4'd5, 4'd5, 4'd5, 4'd6, 4'd5},
	parameter logic [3:0] STROB2_WIDTH = 4'd6
) (
	input logic got,
	input logic clo_,
	input px_pkg::state_vec_t enter,	// Enter levels
	input logic ok,				// Memory OK
	input logic mode,			// Step mode
	input logic step,			// Step pulse
	output px_pkg::state_vec_t state,
	output logic strob1,
	output logic strob2,
	output logic cycle_load
);

	import px_pkg::*;

	grp_vec_t fire;		// Group starts
	grp_vec_t pulses;	// Group strobes
	cycle_info_t info;

	px_state_reg u_state_reg (
		.got        (got),
		.clo_       (clo_),
		.cycle_load (cycle_load),
		.enter      (enter),
		.state      (state)
	);

	px_group_decode u_group_decode (
		.got        (got),
		.clo_       (clo_),
		.cycle_load (cycle_load),
		.state      (state),
		.ok         (ok),
		.fire       (fire),
		.info       (info)
	);

	for (genvar g = 0; g < N_GROUPS; g++) begin : g_strobe
		px_strobe_gen #(
			.WIDTH (STROB1_WIDTHS[g])	// Own width per group
		) u_strobe_gen (
			.got   (got),
			.clo_  (clo_),
			.fire  (fire[g]),
			.pulse (pulses[g])
		);
	end

	px_strobe_merge #(
		.STROB2_WIDTH (STROB2_WIDTH)
	) u_strobe_merge (
		.got        (got),
		.clo_       (clo_),
		.pulses     (pulses),
		.info       (info),
		.mode       (mode),
		.step       (step),
		.strob1     (strob1),
		.strob2     (strob2),
		.cycle_load (cycle_load)
	);

endmodule

// File: hw/px_group_decode.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// P-X strobe group decode
// Maps the loaded state to strobe groups and fires them, OK permitting
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module px_group_decode (
	input logic got,
	input logic clo_,
	input logic cycle_load,			// State loads this cycle
	input px_pkg::state_vec_t state,
	input logic ok,				// Memory OK level
	output px_pkg::grp_vec_t fire,		// One-cycle group starts
	output px_pkg::cycle_info_t info	// Pending set and cycle flags
);

	import px_pkg::*;

	logic load_d;		// First cycle with the new state
	grp_vec_t req;		// Groups asked for by the state
	grp_vec_t avail;	// Groups allowed to fire now
	grp_vec_t fired;	// Groups already fired this cycle

	assign req = state_to_groups(state);
	assign avail = load_d ? req : info.pending;	// Fresh request or leftovers
	assign fire = avail & (~OK_GATED | {N_GROUPS{ok}});	// Gated ones hold for OK

	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			load_d <= 1'b0;
			info <= '0;
			fired <= '0;
		end else begin
			load_d <= cycle_load;
			info.pending <= avail & ~fire;		// Firing retires the group
			if (load_d) begin
				info.long_cycle <= |(req & LONG_GROUPS);
				info.empty <= (req == '0);	// No strobes at all
				fired <= fire;
			end else begin
				fired <= fired | fire;
			end
		end
	end

	// No group fires twice between two state loads
	a_fire_once : assert property (
		@(posedge got) disable iff (!clo_)
		!load_d |-> ((fire & fired) == '0)
	) else $error("strobe group fired twice in one cycle");

endmodule

// File: hw/px_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// P-X state control, shared types
// Cycle state flags, strobe group vectors and the state-to-group map
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package px_pkg;

	localparam int N_GROUPS = 5;		// Strobe groups 1..5

	typedef struct packed {
		logic k1;		// Bit 13
		logic wp;
		logic k2;
		logic wa;
		logic we;
		logic wr;
		logic wd;		// W& state
		logic wz;
		logic p0;
		logic p1;
		logic p2;
		logic p3;
		logic p4;
		logic p5;		// Bit 0
	} state_vec_t;

	typedef logic [N_GROUPS-1:0] grp_vec_t;	// Bit 0 is group 1

	typedef struct packed {
		grp_vec_t pending;	// Requested, not yet fired
		logic long_cycle;	// Group 1 or 2 in this cycle
		logic empty;		// Nothing requested
	} cycle_info_t;

	localparam grp_vec_t OK_GATED = 5'b00110;	// Groups 2, 3 wait for OK
	localparam grp_vec_t LONG_GROUPS = 5'b00011;	// Groups 1, 2 add STROB2

	// State masks, bit order k1 wp k2 wa | we wr wd wz | p0 p1 p2 p3 | p4 p5
	localparam state_vec_t GRP1_STATES = 14'b0000_1010_0000_10;	// WE W& P4
	localparam state_vec_t GRP2_STATES = 14'b1010_0000_0100_00;	// K1 K2 P1
	localparam state_vec_t GRP3_STATES = 14'b0000_0100_0000_01;	// WR P5
	localparam state_vec_t GRP4_STATES = 14'b0001_0001_0001_00;	// WA WZ P3
	localparam state_vec_t GRP5_STATES = 14'b0100_0000_0010_00;	// WP P2

	function automatic grp_vec_t state_to_groups(state_vec_t s);
		grp_vec_t g;
		g[0] = |(s & GRP1_STATES);
		g[1] = |(s & GRP2_STATES);
		g[2] = |(s & GRP3_STATES);
		g[3] = |(s & GRP4_STATES);
		g[4] = |(s & GRP5_STATES);
		return g;		// P0 maps to nothing
	endfunction

endpackage

// File: hw/px_state_reg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// P-X cycle state register
// One-hot cycle states, loaded from the enter lines once per cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module px_state_reg (
	input logic got,			// Cycle clock
	input logic clo_,			// General clear
	input logic cycle_load,			// Load strobe from merger
	input px_pkg::state_vec_t enter,	// Enter levels
	output px_pkg::state_vec_t state	// Current cycle state
);

	import px_pkg::*;

	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			state <= '{p0: 1'b1, default: 1'b0};	// Clear lands in P0
		end else if (cycle_load) begin
			state <= enter;		// New state seen next cycle
		end
	end

	// State only moves on a load issued by the merger
	a_state_hold : assert property (
		@(posedge got) disable iff (!clo_)
		!cycle_load |=> $stable(state)
	) else $error("state changed without cycle_load");

endmodule

// File: hw/px_strobe_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// P-X strobe pulse generator
// Counted stand-in for a one-shot, WIDTH clocks, not retriggerable
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module px_strobe_gen #(
	parameter logic [3:0] WIDTH = 4'd5	// Pulse length in clocks
) (
	input logic got,
	input logic clo_,
	input logic fire,		// Start request
	output logic pulse		// Group strobe
);

	logic [3:0] cnt;		// Clocks left, counts down

	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			pulse <= 1'b0;
			cnt <= '0;
		end else if (pulse) begin
			if (cnt == 4'd1) begin
				pulse <= 1'b0;		// Last clock of the pulse
			end
			cnt <= cnt - 4'd1;
		end else if (fire) begin	// Fire during a pulse is dropped
			pulse <= 1'b1;
			cnt <= WIDTH;
		end
	end

	// Pulse drops right after WIDTH clocks
	a_width : assert property (
		@(posedge got) disable iff (!clo_)
		$rose(pulse) |-> ##WIDTH !pulse
	) else $error("strobe pulse longer than WIDTH");

endmodule

// File: hw/px_strobe_merge.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// P-X strobe merge and cycle sequencing
// STROB1 from the group pulses, then step wait, STROB2 and next load
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module px_strobe_merge #(
	parameter logic [3:0] STROB2_WIDTH = 4'd6	// STROB2 length in clocks
) (
	input logic got,
	input logic clo_,
	input px_pkg::grp_vec_t pulses,		// Group strobes
	input px_pkg::cycle_info_t info,	// From group decode
	input logic mode,			// Step mode level
	input logic step,			// Step pulse
	output logic strob1,
	output logic strob2,
	output logic cycle_load			// Next state load
);

	import px_pkg::*;

	typedef enum logic [2:0] {
		PH_IDLE,		// Just out of clear
		PH_LOAD,		// cycle_load high
		PH_PRIME,		// Decode sees the new state
		PH_S1,			// STROB1 running or pending
		PH_STEP,		// Held for a step pulse
		PH_S2			// STROB2 running
	} phase_t;

	phase_t phase;
	phase_t phase_next;
	phase_t after_s1;	// Where the cycle goes once released
	logic [3:0] s2_cnt;	// STROB2 clocks left
	logic seen;		// STROB1 went high this cycle
	logic s1_done;		// Strobe phase over

	assign strob1 = |pulses;	// Merged group strobes
	assign s1_done = info.empty || (seen && !strob1 && (info.pending == '0));
	assign after_s1 = info.long_cycle ? PH_S2 : PH_LOAD;

	always_comb begin
		phase_next = phase;
		case (phase)
			PH_IDLE: phase_next = PH_LOAD;
			PH_LOAD: phase_next = PH_PRIME;
			PH_PRIME: phase_next = PH_S1;
			PH_S1: begin
				if (s1_done) begin
					phase_next = mode ? PH_STEP : after_s1;
				end
			end
			PH_STEP: begin
				if (step || !mode) begin	// Leaving step mode also releases
					phase_next = after_s1;
				end
			end
			PH_S2: begin
				if (s2_cnt == '0) begin
					phase_next = PH_LOAD;
				end
			end
			default: phase_next = PH_IDLE;
		endcase
	end

	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			phase <= PH_IDLE;
			cycle_load <= 1'b0;
			strob2 <= 1'b0;
			s2_cnt <= '0;
			seen <= 1'b0;
		end else begin
			phase <= phase_next;
			cycle_load <= (phase_next == PH_LOAD);	// One clock per load
			seen <= (phase == PH_S1) && (seen || strob1);
			if ((phase_next == PH_S2) && (phase != PH_S2)) begin
				strob2 <= 1'b1;			// Starts next clock
				s2_cnt <= STROB2_WIDTH - 4'd1;
			end else if (phase == PH_S2) begin
				if (s2_cnt == '0) begin
					strob2 <= 1'b0;
				end else begin
					s2_cnt <= s2_cnt - 4'd1;
				end
			end
		end
	end

	// STROB2 only ever follows a finished STROB1
	a_no_overlap : assert property (
		@(posedge got) disable iff (!clo_)
		!(strob1 && strob2)
	) else $error("strob1 and strob2 high together");

	// Group pulses are all over before the next load
	a_load_quiet : assert property (
		@(posedge got) disable iff (!clo_)
		cycle_load |-> !strob1
	) else $error("cycle_load during strob1");

endmodule

// File: run_sim.sh
#!/bin/sh
# Build the P-X cycle control testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f verilog.f \
	--top-module px_tb \
	-o px_sim

./obj_dir/px_sim > sim.log 2>&1
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
	echo "simulation failed"
	exit 1
fi

echo "simulation passed"
exit 0

// File: verif/px_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// P-X cycle control testbench
// Directed cycles through every strobe group, OK gating, step and empty
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module px_tb;

	import px_pkg::*;

	localparam int STROB1_W [N_GROUPS] = '{5, 6, 5, 5, 5};	// Groups 1..5
	localparam int STROB2_W = 6;
	localparam int LIMIT = 200;		// Clocks allowed per wait
	localparam int QUIET = 30;		// Hold window for gate and step

	logic got;
	logic clo_;
	state_vec_t enter;
	logic ok;
	logic mode;
	logic step;
	state_vec_t state;
	logic strob1;
	logic strob2;
	logic cycle_load;

	int n_checks;
	int n_errors;
	logic [31:0] rng;

	px_cycle_ctrl UUT (
		.got        (got),
		.clo_       (clo_),
		.enter      (enter),
		.ok         (ok),
		.mode       (mode),
		.step       (step),
		.state      (state),
		.strob1     (strob1),
		.strob2     (strob2),
		.cycle_load (cycle_load)
	);

	initial begin
		got = 1'b0;
		forever #10 got = ~got;		// 20 ns period
	end

	// Group map as read from the decode sheet
	function automatic grp_vec_t expected_groups(state_vec_t s);
		grp_vec_t g;
		g[0] = s.we | s.wd | s.p4;
		g[1] = s.p1 | s.k1 | s.k2;
		g[2] = s.p5 | s.wr;
		g[3] = s.wz | s.p3 | s.wa;
		g[4] = s.p2 | s.wp;
		return g;
	endfunction

	function automatic int largest_width(grp_vec_t g);
		int w;
		w = 0;
		for (int i = 0; i < N_GROUPS; i++) begin
			if (g[i] && STROB1_W[i] > w) w = STROB1_W[i];
		end
		return w;
	endfunction

	function automatic logic [31:0] lcg_next(logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;	// Numerical Recipes constants
	endfunction

	task automatic expect_int(input string what, input int act, input int exp);
		n_checks++;
		assert (act == exp) else begin
			n_errors++;
			$display("mismatch at %0t: %s is %0d, expected %0d", $time, what, act, exp);
		end
	endtask

	task automatic expect_state(input state_vec_t exp);
		n_checks++;
		assert (state == exp) else begin
			n_errors++;
			$display("mismatch at %0t: state is %b, expected %b", $time, state, exp);
		end
	endtask

	task automatic expect_done(input string what, input int n);
		n_checks++;
		assert (n < LIMIT) else begin
			n_errors++;
			$display("timeout at %0t: no %s within %0d clocks", $time, what, LIMIT);
		end
	endtask

	// Returns on a falling edge with cycle_load high
	task automatic wait_load();
		int n;
		n = 0;
		while (cycle_load !== 1'b1 && n < LIMIT) begin
			@(negedge got);
			n++;
		end
		expect_done("cycle_load", n);
	endtask

	task automatic load_state(input state_vec_t e);
		enter = e;			// Taken on the next rising edge
		@(negedge got);
		expect_state(e);
	endtask

	task automatic wait_strob1();
		int n;
		n = 0;
		while (strob1 !== 1'b1 && n < LIMIT) begin
			@(negedge got);
			n++;
		end
		expect_done("strob1", n);
	endtask

	task automatic measure_strob1(output int w);
		w = 0;
		while (strob1 === 1'b1 && w < LIMIT) begin
			expect_int("strob2 during strob1", int'(strob2), 0);
			w++;
			@(negedge got);
		end
	endtask

	// Counts strob2 clocks up to the next load
	task automatic measure_strob2(output int w);
		int n;
		w = 0;
		n = 0;
		while (cycle_load !== 1'b1 && n < LIMIT) begin
			expect_int("strob1 after its pulse", int'(strob1), 0);
			if (strob2) w++;
			@(negedge got);
			n++;
		end
		expect_done("cycle_load after strob2", n);
	endtask

	task automatic run_cycle(input state_vec_t e);
		grp_vec_t g;
		int w1;
		int w2;
		g = expected_groups(e);
		wait_load();
		load_state(e);
		wait_strob1();
		measure_strob1(w1);
		expect_int("strob1 width", w1, largest_width(g));
		measure_strob2(w2);
		expect_int("strob2 width", w2, (g[0] || g[1]) ? STROB2_W : 0);
	endtask

	task automatic check_reset();
		expect_state('{p0: 1'b1, default: 1'b0});
		expect_int("strob1 in reset", int'(strob1), 0);
		expect_int("strob2 in reset", int'(strob2), 0);
		expect_int("cycle_load in reset", int'(cycle_load), 0);
	endtask

	task automatic single_states();
		for (int b = 0; b < 14; b++) begin
			if (b != 5) begin		// Bit 5 is P0 and maps to no group
				run_cycle(state_vec_t'(14'b1 << b));
			end
		end
	endtask

	task automatic ok_gating();
		int w1;
		int w2;
		wait_load();
		ok = 1'b0;
		load_state('{p1: 1'b1, default: 1'b0});		// Group 2, gated
		repeat (QUIET) begin
			expect_int("strob1 without ok", int'(strob1), 0);
			expect_int("cycle_load without ok", int'(cycle_load), 0);
			@(negedge got);
		end
		ok = 1'b1;
		wait_strob1();
		measure_strob1(w1);
		expect_int("gated strob1 width", w1, STROB1_W[1]);
		measure_strob2(w2);
		expect_int("gated strob2 width", w2, STROB2_W);
	endtask

	task automatic random_pairs();
		logic [13:0] bits;
		int idx;
		int b1;
		int b2;
		for (int i = 0; i < 8; i++) begin
			rng = lcg_next(rng);
			idx = int'((rng >> 16) % 32'd13);
			b1 = (idx >= 5) ? idx + 1 : idx;		// Skip P0
			rng = lcg_next(rng);
			idx = int'((rng >> 16) % 32'd13);
			b2 = (idx >= 5) ? idx + 1 : idx;
			bits = (14'b1 << b1) | (14'b1 << b2);
			run_cycle(state_vec_t'(bits));
		end
	endtask

	task automatic step_mode();
		int w1;
		int w2;
		wait_load();
		mode = 1'b1;
		load_state('{we: 1'b1, default: 1'b0});		// Group 1, long cycle
		wait_strob1();
		measure_strob1(w1);
		expect_int("step strob1 width", w1, STROB1_W[0]);
		repeat (QUIET) begin
			expect_int("strob2 before step", int'(strob2), 0);
			expect_int("cycle_load before step", int'(cycle_load), 0);
			@(negedge got);
		end
		step = 1'b1;			// One clock wide
		@(negedge got);
		step = 1'b0;
		measure_strob2(w2);		// Mode still set, only step can release
		expect_int("strob2 after step", w2, STROB2_W);
		mode = 1'b0;
	endtask

	task automatic empty_cycles();
		int n;
		repeat (3) begin
			wait_load();
			load_state('0);
			n = 0;
			while (cycle_load !== 1'b1 && n < LIMIT) begin
				expect_int("strob1 in empty cycle", int'(strob1), 0);
				expect_int("strob2 in empty cycle", int'(strob2), 0);
				@(negedge got);
				n++;
			end
			expect_done("cycle_load after empty cycle", n);
		end
	endtask

	initial begin
		n_checks = 0;
		n_errors = 0;
		rng = 32'h73d3b450;
		clo_ = 1'b0;
		enter = '{p0: 1'b1, default: 1'b0};
		ok = 1'b1;
		mode = 1'b0;
		step = 1'b0;
		repeat (5) @(negedge got);	// Clear held 5 clocks
		check_reset();
		clo_ = 1'b1;
		single_states();
		ok_gating();
		random_pairs();
		step_mode();
		empty_cycles();
		$display("px_tb: %0d checks, %0d errors", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// File: verilog.f
hw/px_pkg.sv
hw/px_state_reg.sv
hw/px_group_decode.sv
hw/px_strobe_gen.sv
hw/px_strobe_merge.sv
hw/px_cycle_ctrl.sv
verif/px_tb.sv
